// ==== design/msx_defines.svh ====
// TMS9918 raster constants in pixel enables and lines, reset hold counted in clk_sys cycles
`ifndef MSX_DEFINES_SVH
`define MSX_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Raster geometry
////////////////////////////////////////////////////////////////////////////

// Pixel enables per line and lines per frame
`define H_TOTAL 342
`define V_TOTAL 262

// Visible area, starting at pixel 0 of line 0
`define H_ACTIVE 256
`define V_ACTIVE 192

// Horizontal sync, both ends inclusive
`define HS_START 280
`define HS_END 305

// Vertical sync lines, both ends inclusive
`define VS_START 216
`define VS_END 218

// Core reset stretch after the last source falls
`define RESET_HOLD 16

`endif

// ==== design/video_pkg.sv ====
// Video path types, widths sized for a 342 x 262 raster and the 16 entry palette
package video_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Raster position
	////////////////////////////////////////////////////////////////////////////

	// Horizontal position, 0 to 341
	typedef logic [8:0] pixel_x_t;

	// Line number, 0 to 261
	typedef logic [8:0] line_y_t;

	////////////////////////////////////////////////////////////////////////////
	// Colour
	////////////////////////////////////////////////////////////////////////////

	// Index into the TMS9918 palette
	typedef logic [3:0] color_idx_t;

	// One of red, green or blue
	typedef logic [7:0] chan_t;

endpackage

// ==== design/ctrl_pkg.sv ====
// Control side types, status bit 0 is the menu reset and bits 4 to 1 rotate the picture
package ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Platform inputs
	////////////////////////////////////////////////////////////////////////////

	// Menu status word
	// Bit 0 menu reset
	// Bits 4 to 1 colour rotation
	typedef logic [31:0] status_word_t;

	// Board buttons
	// Bit 1 user button, bit 0 menu button
	typedef logic [1:0] button_t;

	////////////////////////////////////////////////////////////////////////////
	// Reset sequencer
	////////////////////////////////////////////////////////////////////////////

	// HOLD keeps the core in reset, RUN releases it
	typedef enum logic {
		HOLD,
		RUN
	} rst_state_t;

endpackage

// ==== design/ce_divider.sv ====
// Clock enables at a quarter and an eighth of clk_sys, both low during rst and one cycle after
`timescale 1ns/10ps

module ce_divider (
	input  logic clk_sys,
	input  logic rst,
	output logic ce_10m7,
	output logic ce_5m3
);

	// Free-running phase counter
	logic [2:0] div;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div     <= '0;
			ce_10m7 <= 1'b0;
			ce_5m3  <= 1'b0;
		end else begin
			div <= div + 3'd1;
			// Quarter rate, one pulse per four cycles
			ce_10m7 <= (div[1:0] == 2'd0);
			// Eighth rate, always on a quarter rate pulse
			ce_5m3 <= (div == 3'd0);
		end
	end

endmodule

// ==== design/reset_sequencer.sv ====
// Core reset stays high while any source is high and for RESET_HOLD cycles after the last falls
`timescale 1ns/10ps
`include "msx_defines.svh"

module reset_sequencer (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  ctrl_pkg::status_word_t status,
	input  ctrl_pkg::button_t      buttons,
	output logic                  core_reset
);

	import ctrl_pkg::*;

	// Wide enough to count up to RESET_HOLD
	localparam int CNT_W = $clog2(`RESET_HOLD + 1);

	rst_state_t       state;
	logic [CNT_W-1:0] hold_cnt;
	logic             src_reset;

	// Platform reset, menu reset and user button
	assign src_reset = rst | status[0] | buttons[1];

	////////////////////////////////////////////////////////////////////////////
	// Hold FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (src_reset) begin
			// Any source restarts the hold
			state    <= HOLD;
			hold_cnt <= '0;
		end else begin
			case (state)
				HOLD: begin
					hold_cnt <= hold_cnt + 1'b1;
					// Last quiet cycle of the hold
					if (hold_cnt == CNT_W'(`RESET_HOLD - 1)) begin
						state <= RUN;
					end
				end
				RUN: begin
					hold_cnt <= '0;
				end
				default: begin
					state <= HOLD;
				end
			endcase
		end
	end

	// High at once with a source, low after the hold
	assign core_reset = src_reset | (state == HOLD);

endmodule

// ==== design/vdp_timing.sv ====
// Raster counters step on ce_5m3 only, outputs are registered and held at 0 during core_reset
`timescale 1ns/10ps
`include "msx_defines.svh"

module vdp_timing (
	input  logic                clk_sys,
	input  logic                core_reset,
	input  logic                ce_5m3,
	output video_pkg::pixel_x_t hpos,
	output video_pkg::line_y_t  vpos,
	output logic                hs_raw,
	output logic                vs_raw,
	output logic                de_raw
);

	import video_pkg::*;

	// Position of the pixel that the next enable presents
	pixel_x_t h_cnt;
	line_y_t  v_cnt;
	logic     h_last;
	logic     v_last;
	logic     h_sync;
	logic     v_sync;
	logic     active;

	assign h_last = (h_cnt == pixel_x_t'(`H_TOTAL - 1));
	assign v_last = (v_cnt == line_y_t'(`V_TOTAL - 1));

	// Sync windows, active high
	assign h_sync = (h_cnt >= pixel_x_t'(`HS_START)) && (h_cnt <= pixel_x_t'(`HS_END));
	assign v_sync = (v_cnt >= line_y_t'(`VS_START)) && (v_cnt <= line_y_t'(`VS_END));

	// Visible area
	assign active = (h_cnt < pixel_x_t'(`H_ACTIVE)) && (v_cnt < line_y_t'(`V_ACTIVE));

	////////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (ce_5m3) begin
			if (h_last) begin
				h_cnt <= '0;
				// Line wrap steps the frame
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Registered decodes
	////////////////////////////////////////////////////////////////////////////

	// First enable after reset shows pixel 0 of line 0
	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			hpos   <= '0;
			vpos   <= '0;
			hs_raw <= 1'b0;
			vs_raw <= 1'b0;
			de_raw <= 1'b0;
		end else if (ce_5m3) begin
			hpos   <= h_cnt;
			vpos   <= v_cnt;
			hs_raw <= h_sync;
			vs_raw <= v_sync;
			de_raw <= active;
		end
	end

endmodule

// ==== design/vdp_colorizer.sv ====
// Colour bar picture through the fixed TMS9918 palette, colour and sync share one register stage
`timescale 1ns/10ps
`include "msx_defines.svh"

module vdp_colorizer (
	input  logic                  clk_sys,
	input  logic                  core_reset,
	input  video_pkg::pixel_x_t   hpos,
	input  video_pkg::line_y_t    vpos,
	input  logic                  hs_raw,
	input  logic                  vs_raw,
	input  logic                  de_raw,
	input  video_pkg::color_idx_t rotate,
	output video_pkg::chan_t      vga_r,
	output video_pkg::chan_t      vga_g,
	output video_pkg::chan_t      vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  vga_de
);

	import video_pkg::*;

	color_idx_t  idx;
	logic        pix_on;
	logic [23:0] rgb;

	// Fixed TMS9918 colours, 0xRRGGBB
	function automatic logic [23:0] palette(input color_idx_t c);
		case (c)
			4'd0:    palette = 24'h000000;
			4'd1:    palette = 24'h000000;
			4'd2:    palette = 24'h21C842;
			4'd3:    palette = 24'h5EDC78;
			4'd4:    palette = 24'h5455ED;
			4'd5:    palette = 24'h7D76FC;
			4'd6:    palette = 24'hD4524D;
			4'd7:    palette = 24'h42EBF5;
			4'd8:    palette = 24'hFC5554;
			4'd9:    palette = 24'hFF7978;
			4'd10:   palette = 24'hD4C154;
			4'd11:   palette = 24'hE6CE80;
			4'd12:   palette = 24'h21B03B;
			4'd13:   palette = 24'hC95BBA;
			4'd14:   palette = 24'hCCCCCC;
			default: palette = 24'hFFFFFF;
		endcase
	endfunction

	// 16 bars of 16 pixels, shifted by the rotation and wrapping at 16
	assign idx = hpos[7:4] + rotate;

	// Blank outside the visible window
	assign pix_on = de_raw && (hpos < pixel_x_t'(`H_ACTIVE)) && (vpos < line_y_t'(`V_ACTIVE));

	assign rgb = pix_on ? palette(idx) : 24'h000000;

	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_de <= 1'b0;
		end else begin
			{vga_r, vga_g, vga_b} <= rgb;
			vga_hs <= hs_raw;
			vga_vs <= vs_raw;
			vga_de <= pix_on;
		end
	end

endmodule

// ==== design/msx1_core.sv ====
// MSX1 core holding only the video raster and test picture, the CPU side is not present
`timescale 1ns/10ps

module msx1_core (
	input  logic                  clk_sys,
	input  logic                  core_reset,
	input  logic                  ce_10m7,
	input  logic                  ce_5m3,
	input  video_pkg::color_idx_t rotate,
	output video_pkg::chan_t      vga_r,
	output video_pkg::chan_t      vga_g,
	output video_pkg::chan_t      vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  vga_de
);

	import video_pkg::*;

	// ce_10m7 is the CPU side enable, nothing runs on it yet

	// Raster position and raw sync
	pixel_x_t hpos;
	line_y_t  vpos;
	logic     hs_raw;
	logic     vs_raw;
	logic     de_raw;

	vdp_timing vdp_timing_i (
		.clk_sys    (clk_sys),
		.core_reset (core_reset),
		.ce_5m3     (ce_5m3),
		.hpos       (hpos),
		.vpos       (vpos),
		.hs_raw     (hs_raw),
		.vs_raw     (vs_raw),
		.de_raw     (de_raw)
	);

	vdp_colorizer vdp_colorizer_i (
		.clk_sys    (clk_sys),
		.core_reset (core_reset),
		.hpos       (hpos),
		.vpos       (vpos),
		.hs_raw     (hs_raw),
		.vs_raw     (vs_raw),
		.de_raw     (de_raw),
		.rotate     (rotate),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.vga_de     (vga_de)
	);

endmodule

// ==== design/emu_shell.sv ====
// Platform shell with clk_sys from outside and no PLL, ce_pixel is the eighth rate enable
`timescale 1ns/10ps

module emu_shell (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  ctrl_pkg::status_word_t status,
	input  ctrl_pkg::button_t      buttons,
	output logic                   ce_pixel,
	output video_pkg::chan_t       vga_r,
	output video_pkg::chan_t       vga_g,
	output video_pkg::chan_t       vga_b,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output logic                   vga_de
);

	////////////////////////////////////////////////////////////////////////////
	// Clock enables and reset
	////////////////////////////////////////////////////////////////////////////

	logic ce_10m7;
	logic core_reset;

	// The pixel enable doubles as the video clock enable
	ce_divider ce_divider_i (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_10m7 (ce_10m7),
		.ce_5m3  (ce_pixel)
	);

	reset_sequencer reset_sequencer_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.status     (status),
		.buttons    (buttons),
		.core_reset (core_reset)
	);

	////////////////////////////////////////////////////////////////////////////
	// Core
	////////////////////////////////////////////////////////////////////////////

	// Status bits 4 to 1 rotate the bar colours
	msx1_core msx1_core_i (
		.clk_sys    (clk_sys),
		.core_reset (core_reset),
		.ce_10m7    (ce_10m7),
		.ce_5m3     (ce_pixel),
		.rotate     (status[4:1]),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.vga_de     (vga_de)
	);

endmodule

// ==== bench/emu_shell_properties.sv ====
// Video and clock enable checks bound into emu_shell, all checks are off while rst is high
`timescale 1ns/10ps

module emu_shell_properties (
	input logic             clk_sys,
	input logic             rst,
	input logic             ce_10m7,
	input logic             ce_pixel,
	input video_pkg::chan_t vga_r,
	input video_pkg::chan_t vga_g,
	input video_pkg::chan_t vga_b,
	input logic             vga_hs,
	input logic             vga_vs,
	input logic             vga_de
);

	// Number of assertion failures so far
	int fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// Video output
	////////////////////////////////////////////////////////////////////////////

	// Active area lies outside both sync windows
	de_outside_sync: assert property (@(posedge clk_sys) disable iff (rst)
		!(vga_de && (vga_hs || vga_vs)))
		else begin
			fail_count++;
			$error("vga_de is high during a sync pulse");
		end

	// Blanking shows black
	black_when_blank: assert property (@(posedge clk_sys) disable iff (rst)
		!vga_de |-> ({vga_r, vga_g, vga_b} == 24'h000000))
		else begin
			fail_count++;
			$error("RGB is not black while vga_de is low");
		end

	////////////////////////////////////////////////////////////////////////////
	// Clock enables
	////////////////////////////////////////////////////////////////////////////

	// Pixel enable sits on a quarter rate pulse
	pixel_on_quarter: assert property (@(posedge clk_sys) disable iff (rst)
		ce_pixel |-> ce_10m7)
		else begin
			fail_count++;
			$error("ce_5m3 pulse without ce_10m7");
		end

endmodule

bind emu_shell emu_shell_properties emu_shell_properties_i (
	.clk_sys  (clk_sys),
	.rst      (rst),
	.ce_10m7  (ce_10m7),
	.ce_pixel (ce_pixel),
	.vga_r    (vga_r),
	.vga_g    (vga_g),
	.vga_b    (vga_b),
	.vga_hs   (vga_hs),
	.vga_vs   (vga_vs),
	.vga_de   (vga_de)
);

// ==== bench/emu_shell_tb.sv ====
// Directed tests with a 100 ns clk_sys, a full run needs a little over two video frames
`timescale 1ns/10ps
`include "msx_defines.svh"

module emu_shell_tb;

	import video_pkg::*;
	import ctrl_pkg::*;

	localparam int SEL_HS = 0;
	localparam int SEL_VS = 1;
	localparam int SEL_DE = 2;
	// Three frames of clk_sys cycles plus some slack
	localparam int WATCHDOG_CYCLES = 3 * `H_TOTAL * `V_TOTAL * 8 + 100000;

	logic         clk_sys = 1'b0;
	logic         rst;
	status_word_t status;
	button_t      buttons;
	logic         ce_pixel;
	chan_t        vga_r;
	chan_t        vga_g;
	chan_t        vga_b;
	logic         vga_hs;
	logic         vga_vs;
	logic         vga_de;
	int           checks = 0;
	int           errors = 0;
	int unsigned  seed = 84066;

	emu_shell emu_shell_i (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.status   (status),
		.buttons  (buttons),
		.ce_pixel (ce_pixel),
		.vga_r    (vga_r),
		.vga_g    (vga_g),
		.vga_b    (vga_b),
		.vga_hs   (vga_hs),
		.vga_vs   (vga_vs),
		.vga_de   (vga_de)
	);

	always #50 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// Reference model and helpers
	////////////////////////////////////////////////////////////////////////////

	// TMS9918 palette as 0xRRGGBB
	function automatic logic [23:0] tms_color(input int idx);
		case (idx)
			0, 1:    tms_color = 24'h000000;
			2:       tms_color = 24'h21C842;
			3:       tms_color = 24'h5EDC78;
			4:       tms_color = 24'h5455ED;
			5:       tms_color = 24'h7D76FC;
			6:       tms_color = 24'hD4524D;
			7:       tms_color = 24'h42EBF5;
			8:       tms_color = 24'hFC5554;
			9:       tms_color = 24'hFF7978;
			10:      tms_color = 24'hD4C154;
			11:      tms_color = 24'hE6CE80;
			12:      tms_color = 24'h21B03B;
			13:      tms_color = 24'hC95BBA;
			14:      tms_color = 24'hCCCCCC;
			default: tms_color = 24'hFFFFFF;
		endcase
	endfunction

	function automatic int unsigned lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic video_bit(input int sel);
		case (sel)
			SEL_HS:  video_bit = vga_hs;
			SEL_VS:  video_bit = vga_vs;
			default: video_bit = vga_de;
		endcase
	endfunction

	task automatic check_chan(input string name, input chan_t got, input chan_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_rgb(input logic [23:0] exp);
		check_chan("vga_r", vga_r, exp[23:16]);
		check_chan("vga_g", vga_g, exp[15:8]);
		check_chan("vga_b", vga_b, exp[7:0]);
	endtask

	// One sample per pixel, taken mid cycle while ce_pixel is high
	task automatic next_pixel();
		do @(negedge clk_sys); while (ce_pixel !== 1'b1);
	endtask

	task automatic wait_rise(input int sel);
		logic prev;
		logic cur;
		cur = video_bit(sel);
		do begin
			prev = cur;
			next_pixel();
			cur = video_bit(sel);
		end while (!(cur && !prev));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_reset();
		int i;
		for (i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			if (i == 7) rst <= 1'b0;
			@(negedge clk_sys);
			check_bit("ce_pixel", ce_pixel, 1'b0);
		end
	endtask

	task automatic test_ce_pixel();
		int   i;
		int   last;
		logic prev;
		last = -1;
		prev = 1'b0;
		for (i = 0; i < 80; i++) begin
			@(negedge clk_sys);
			if (ce_pixel && prev) begin
				errors++;
				$display("Error at %0t ns: ce_pixel is high on two cycles in a row", $time);
			end
			if (ce_pixel) begin
				if (last >= 0) check_count("ce_pixel period", i - last, 8);
				last = i;
			end
			prev = ce_pixel;
		end
		if (last < 0) begin
			errors++;
			$display("Error at %0t ns: ce_pixel never pulsed after reset", $time);
		end
	endtask

	// From one hsync rise to the next
	task automatic test_line();
		int   pix;
		int   de_cnt;
		int   hs_cnt;
		logic prev;
		pix = 0;
		de_cnt = 0;
		hs_cnt = 0;
		wait_rise(SEL_HS);
		do begin
			pix++;
			de_cnt += vga_de;
			hs_cnt += vga_hs;
			prev = vga_hs;
			next_pixel();
		end while (!(vga_hs && !prev));
		check_count("pixels per line", pix, `H_TOTAL);
		check_count("vga_de pixels per line", de_cnt, `H_ACTIVE);
		check_count("vga_hs pixels per line", hs_cnt, `HS_END - `HS_START + 1);
	endtask

	// From one vsync rise to the next, lines counted on hsync rises
	task automatic test_frame();
		int   lines;
		int   de_lines;
		int   vs_lines;
		logic prev_hs;
		logic prev_vs;
		logic prev_de;
		lines = 0;
		de_lines = 0;
		vs_lines = 0;
		wait_rise(SEL_VS);
		prev_hs = vga_hs;
		prev_de = vga_de;
		do begin
			if (vga_hs && !prev_hs) begin
				lines++;
				if (vga_vs) vs_lines++;
			end
			if (vga_de && !prev_de) de_lines++;
			prev_hs = vga_hs;
			prev_vs = vga_vs;
			prev_de = vga_de;
			next_pixel();
		end while (!(vga_vs && !prev_vs));
		check_count("lines per frame", lines, `V_TOTAL);
		check_count("vga_de lines per frame", de_lines, `V_ACTIVE);
		check_count("vga_vs lines per frame", vs_lines, `VS_END - `VS_START + 1);
	endtask

	// Rotation changes only during blanking, then one full active line is checked
	task automatic test_colors(input int count);
		int k;
		int n;
		int rot;
		for (k = 0; k < count; k++) begin
			rot = (lcg_next() >> 16) & 15;
			@(posedge clk_sys);
			status[4:1] <= 4'(rot);
			wait_rise(SEL_DE);
			for (n = 0; n < `H_ACTIVE; n++) begin
				check_bit("vga_de", vga_de, 1'b1);
				check_rgb(tms_color((n / 16 + rot) % 16));
				next_pixel();
			end
		end
	endtask

	// Source 0 is the menu reset bit, source 1 the user button
	task automatic test_reset_pulse(input int src);
		int   i;
		int   waited;
		logic seen;
		@(posedge clk_sys);
		if (src == 0) status[0] <= 1'b1;
		else buttons[1] <= 1'b1;
		repeat (4) @(posedge clk_sys);
		if (src == 0) status[0] <= 1'b0;
		else buttons[1] <= 1'b0;
		for (i = 0; i < `RESET_HOLD; i++) begin
			@(negedge clk_sys);
			check_bit("vga_de", vga_de, 1'b0);
		end
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < 10) begin
			@(negedge clk_sys);
			waited++;
			seen = vga_de;
		end
		if (!seen) begin
			errors++;
			$display("Error at %0t ns: no active pixel within 10 cycles after the reset hold",
				$time);
		end else begin
			// Raster restarts at pixel 0 of line 0
			check_rgb(tms_color(int'(status[4:1])));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		status = '0;
		buttons = '0;
		apply_reset();
		test_ce_pixel();
		test_line();
		test_frame();
		test_colors(4);
		test_reset_pulse(0);
		test_reset_pulse(1);
		errors += emu_shell_i.emu_shell_properties_i.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired, a test waited for video that never came");
		$display("Checks: %0d, errors: %0d", checks,
			errors + emu_shell_i.emu_shell_properties_i.fail_count);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+design
design/video_pkg.sv
design/ctrl_pkg.sv
design/ce_divider.sv
design/reset_sequencer.sv
design/vdp_timing.sv
design/vdp_colorizer.sv
design/msx1_core.sv
design/emu_shell.sv
bench/emu_shell_properties.sv
bench/emu_shell_tb.sv
